// File: logic/cpu_bus_pkg.sv
package cpu_bus_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [3:0]  ppu_reg_sel_t;

    // Shift order, A in bit 0 through right in bit 7
    typedef logic [7:0]  button_set_t;

    // Source of the byte returned on the cycle after a read
    typedef logic [2:0]  rd_src_t;

    localparam int RAM_ADDR_BITS  = 11;
    localparam int PROM_ADDR_BITS = 15;

    localparam cpu_addr_t JOYPAD1_ADDR = 16'h4016;
    localparam cpu_addr_t OAMDMA_ADDR  = 16'h4014;

    localparam ppu_reg_sel_t PPUCTRL   = 4'd0;
    localparam ppu_reg_sel_t PPUMASK   = 4'd1;
    localparam ppu_reg_sel_t PPUSTATUS = 4'd2;
    localparam ppu_reg_sel_t OAMADDR   = 4'd3;
    localparam ppu_reg_sel_t OAMDATA   = 4'd4;
    localparam ppu_reg_sel_t PPUSCROLL = 4'd5;
    localparam ppu_reg_sel_t PPUADDR   = 4'd6;
    localparam ppu_reg_sel_t PPUDATA   = 4'd7;
    localparam ppu_reg_sel_t OAMDMA    = 4'd8;

    localparam rd_src_t RD_NONE = 3'd0;
    localparam rd_src_t RD_RAM  = 3'd1;
    localparam rd_src_t RD_PROM = 3'd2;
    localparam rd_src_t RD_PPU  = 3'd3;
    localparam rd_src_t RD_PAD  = 3'd4;

    // $0000-$1FFF
    function automatic logic in_ram_region(cpu_addr_t a);
        return a[15:12] == 4'h0 || a[15:12] == 4'h1;
    endfunction

    // $2000-$3FFF, eight registers repeated every 8 bytes
    function automatic logic in_ppu_region(cpu_addr_t a);
        return a[15:12] == 4'h2 || a[15:12] == 4'h3;
    endfunction

    function automatic logic in_prom_region(cpu_addr_t a);
        return a[15];
    endfunction

endpackage : cpu_bus_pkg

// File: logic/work_ram.sv
module work_ram (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  logic                                 clock_en,
    input  logic [cpu_bus_pkg::RAM_ADDR_BITS-1:0] ram_addr,
    input  logic                                 we,
    input  cpu_bus_pkg::cpu_data_t               w_data,
    output cpu_bus_pkg::cpu_data_t               q
);

    import cpu_bus_pkg::*;

    localparam int DEPTH = 1 << RAM_ADDR_BITS;

    cpu_data_t mem [DEPTH];

    always_ff @(posedge clock) begin
        if (clock_en && we) begin
            mem[ram_addr] <= w_data;
        end
    end

    // Read port holds its last byte across writes
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            q <= '0;
        end else if (clock_en && !we) begin
            q <= mem[ram_addr];
        end
    end

endmodule : work_ram

// File: logic/prg_rom.sv
module prg_rom (
    input  logic                                  clock,
    input  logic                                  clock_en,
    input  logic [cpu_bus_pkg::PROM_ADDR_BITS-1:0] rom_addr,
    output cpu_bus_pkg::cpu_data_t                q
);

    import cpu_bus_pkg::*;

    localparam int DEPTH = 1 << PROM_ADDR_BITS;

    cpu_data_t mem [DEPTH];

    initial begin
        $readmemh("verif/prg_image.hex", mem);
    end

    // Unconditional read, the decoder picks it up only for ROM reads
    always_ff @(posedge clock) begin
        if (clock_en) begin
            q <= mem[rom_addr];
        end
    end

endmodule : prg_rom

// File: logic/controller_port.sv
module controller_port (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     clock_en,
    input  cpu_bus_pkg::button_set_t buttons,
    input  logic                     pad_wr,
    input  logic                     pad_rd,
    input  logic                     strobe_bit,
    output cpu_bus_pkg::cpu_data_t   pad_q
);

    import cpu_bus_pkg::*;

    logic        strobe;
    button_set_t shift_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            strobe <= 1'b0;
        end else if (clock_en && pad_wr) begin
            strobe <= strobe_bit;
        end
    end

    // Ones shift in behind the buttons, so reads past the eighth return 1
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            shift_q <= '1;
        end else if (clock_en) begin
            if (strobe) begin
                shift_q <= buttons;
            end else if (pad_rd) begin
                shift_q <= {1'b1, shift_q[7:1]};
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pad_q <= '0;
        end else if (clock_en && pad_rd) begin
            pad_q <= {7'b0, shift_q[0]};
        end
    end

endmodule : controller_port

// File: logic/cpu_bus_decoder.sv
module cpu_bus_decoder (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      clock_en,
    input  cpu_bus_pkg::cpu_addr_t    addr,
    input  logic                      r_en,
    input  cpu_bus_pkg::cpu_data_t    w_data,
    output cpu_bus_pkg::cpu_data_t    r_data,
    output logic                      ram_we,
    output logic                      pad_wr,
    output logic                      pad_rd,
    output logic                      reg_en,
    output cpu_bus_pkg::ppu_reg_sel_t reg_sel,
    output logic                      reg_rw,
    output cpu_bus_pkg::cpu_data_t    reg_data_wr,
    input  cpu_bus_pkg::cpu_data_t    reg_data_rd,
    input  cpu_bus_pkg::cpu_data_t    ram_q,
    input  cpu_bus_pkg::cpu_data_t    prom_q,
    input  cpu_bus_pkg::cpu_data_t    pad_q
);

    import cpu_bus_pkg::*;

    logic    ram_hit;
    logic    prom_hit;
    logic    pad_hit;
    rd_src_t rd_src;
    rd_src_t rd_src_next;

    assign ram_hit  = in_ram_region(addr);
    assign prom_hit = in_prom_region(addr);
    assign pad_hit  = (addr == JOYPAD1_ADDR);

    assign ram_we = ram_hit && !r_en;
    assign pad_wr = pad_hit && !r_en;
    assign pad_rd = pad_hit && r_en;

    // PPU register port, 1 means write
    assign reg_rw      = ~r_en;
    assign reg_data_wr = w_data;

    always_comb begin
        reg_en  = 1'b0;
        reg_sel = PPUCTRL;
        if (in_ppu_region(addr)) begin
            reg_en = 1'b1;
            case (addr[2:0])
                3'd0: reg_sel = PPUCTRL;
                3'd1: reg_sel = PPUMASK;
                3'd2: reg_sel = PPUSTATUS;
                3'd3: reg_sel = OAMADDR;
                3'd4: reg_sel = OAMDATA;
                3'd5: reg_sel = PPUSCROLL;
                3'd6: reg_sel = PPUADDR;
                default: reg_sel = PPUDATA;
            endcase
        end else if (addr == OAMDMA_ADDR) begin
            reg_en  = 1'b1;
            reg_sel = OAMDMA;
        end
    end

    always_comb begin
        rd_src_next = RD_NONE;
        if (r_en) begin
            if (ram_hit) begin
                rd_src_next = RD_RAM;
            end else if (prom_hit) begin
                rd_src_next = RD_PROM;
            end else if (reg_en) begin
                rd_src_next = RD_PPU;
            end else if (pad_hit) begin
                rd_src_next = RD_PAD;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_src <= RD_NONE;
        end else if (clock_en) begin
            rd_src <= rd_src_next;
        end
    end

    // PPU byte is taken live from the port in the cycle after the access
    always_comb begin
        case (rd_src)
            RD_RAM:  r_data = ram_q;
            RD_PROM: r_data = prom_q;
            RD_PPU:  r_data = reg_data_rd;
            RD_PAD:  r_data = pad_q;
            default: r_data = '0;
        endcase
    end

endmodule : cpu_bus_decoder

// File: logic/cpu_bus.sv
module cpu_bus (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      clock_en,
    input  cpu_bus_pkg::cpu_addr_t    addr,
    input  logic                      r_en,
    input  cpu_bus_pkg::cpu_data_t    w_data,
    output cpu_bus_pkg::cpu_data_t    r_data,
    input  cpu_bus_pkg::button_set_t  buttons,
    output logic                      reg_en,
    output cpu_bus_pkg::ppu_reg_sel_t reg_sel,
    output logic                      reg_rw,
    output cpu_bus_pkg::cpu_data_t    reg_data_wr,
    input  cpu_bus_pkg::cpu_data_t    reg_data_rd
);

    import cpu_bus_pkg::*;

    logic      ram_we;
    logic      pad_wr;
    logic      pad_rd;
    cpu_data_t ram_q;
    cpu_data_t prom_q;
    cpu_data_t pad_q;

    cpu_bus_decoder decoder_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .clock_en    (clock_en),
        .addr        (addr),
        .r_en        (r_en),
        .w_data      (w_data),
        .r_data      (r_data),
        .ram_we      (ram_we),
        .pad_wr      (pad_wr),
        .pad_rd      (pad_rd),
        .reg_en      (reg_en),
        .reg_sel     (reg_sel),
        .reg_rw      (reg_rw),
        .reg_data_wr (reg_data_wr),
        .reg_data_rd (reg_data_rd),
        .ram_q       (ram_q),
        .prom_q      (prom_q),
        .pad_q       (pad_q)
    );

    // Low address bits give the mirrors for free
    work_ram ram_i (
        .clock    (clock),
        .reset_n  (reset_n),
        .clock_en (clock_en),
        .ram_addr (addr[RAM_ADDR_BITS-1:0]),
        .we       (ram_we),
        .w_data   (w_data),
        .q        (ram_q)
    );

    prg_rom rom_i (
        .clock    (clock),
        .clock_en (clock_en),
        .rom_addr (addr[PROM_ADDR_BITS-1:0]),
        .q        (prom_q)
    );

    controller_port pad_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .clock_en   (clock_en),
        .buttons    (buttons),
        .pad_wr     (pad_wr),
        .pad_rd     (pad_rd),
        .strobe_bit (w_data[0]),
        .pad_q      (pad_q)
    );

endmodule : cpu_bus

// File: verif/cpu_bus_properties.sv
module cpu_bus_properties (
    input logic                   clock,
    input logic                   reset_n,
    input logic                   clock_en,
    input logic                   r_en,
    input logic                   ram_we,
    input logic                   reg_en,
    input logic                   reg_rw,
    input cpu_bus_pkg::cpu_data_t r_data
);

    timeunit 1ns;
    timeprecision 1ps;

    int   failures = 0;
    logic read_seen;

    // Set by the first enabled read after reset
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_seen <= 1'b0;
        end else if (clock_en && r_en) begin
            read_seen <= 1'b1;
        end
    end

    rw_follows_r_en: assert property (
        @(posedge clock) disable iff (!reset_n) reg_rw == !r_en
    ) else begin
        failures++;
        $error("reg_rw is not the inverse of r_en");
    end

    ram_and_ppu_exclusive: assert property (
        @(posedge clock) disable iff (!reset_n) !(ram_we && reg_en)
    ) else begin
        failures++;
        $error("ram_we and reg_en are high together");
    end

    idle_r_data_zero: assert property (
        @(posedge clock) disable iff (!reset_n) !read_seen |-> r_data == '0
    ) else begin
        failures++;
        $error("r_data is not zero before the first enabled read");
    end

endmodule : cpu_bus_properties

// File: verif/tb_cpu_bus.sv
module tb_cpu_bus;

    timeunit 1ns;
    timeprecision 1ps;

    import cpu_bus_pkg::*;

    localparam int    CLK_PERIOD = 40;
    localparam string STIM_FILE  = "verif/cpu_bus_stim.txt";

    logic         clock;
    logic         reset_n;
    logic         clock_en;
    cpu_addr_t    addr;
    logic         r_en;
    cpu_data_t    w_data;
    cpu_data_t    r_data;
    button_set_t  buttons;
    logic         reg_en;
    ppu_reg_sel_t reg_sel;
    logic         reg_rw;
    cpu_data_t    reg_data_wr;
    cpu_data_t    reg_data_rd;

    // One entry per stim line
    logic [7:0] op_q[$];
    logic       ce_q[$];
    cpu_addr_t  addr_q[$];
    cpu_data_t  data_q[$];
    cpu_data_t  exp_q[$];

    int         stim_lines = 0;
    logic       stim_ready = 1'b0;
    int         data_errors = 0;
    int         sel_errors = 0;
    int         flag_errors = 0;
    int         stim_errors = 0;
    int         assert_fails;

    // Read waiting for its byte in the next cycle
    logic       read_pending = 1'b0;
    cpu_addr_t  read_addr;
    cpu_data_t  read_expect;

    cpu_bus dut_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .clock_en    (clock_en),
        .addr        (addr),
        .r_en        (r_en),
        .w_data      (w_data),
        .r_data      (r_data),
        .buttons     (buttons),
        .reg_en      (reg_en),
        .reg_sel     (reg_sel),
        .reg_rw      (reg_rw),
        .reg_data_wr (reg_data_wr),
        .reg_data_rd (reg_data_rd)
    );

    bind cpu_bus_decoder cpu_bus_properties props_i (
        .clock    (clock),
        .reset_n  (reset_n),
        .clock_en (clock_en),
        .r_en     (r_en),
        .ram_we   (ram_we),
        .reg_en   (reg_en),
        .reg_rw   (reg_rw),
        .r_data   (r_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic check_data(input cpu_data_t got, input cpu_data_t exp, input string what);
        if (got !== exp) begin
            data_errors = data_errors + 1;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ppu_sel(input ppu_reg_sel_t got, input ppu_reg_sel_t exp,
                                 input string what);
        if (got !== exp) begin
            sel_errors = sel_errors + 1;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors = flag_errors + 1;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Register code from the address rule, 8 for OAMDMA
    function automatic void ppu_sel_for_addr(input cpu_addr_t a, output logic en,
                                             output ppu_reg_sel_t sel);
        en  = 1'b0;
        sel = '0;
        if (a[15:12] == 4'h2 || a[15:12] == 4'h3) begin
            en  = 1'b1;
            sel = {1'b0, a[2:0]};
        end else if (a == OAMDMA_ADDR) begin
            en  = 1'b1;
            sel = OAMDMA;
        end
    endfunction

    task automatic load_stim();
        int         fd;
        int         n;
        int         ce;
        string      line;
        logic [7:0] op;
        cpu_addr_t  a;
        cpu_data_t  d;
        cpu_data_t  e;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stim_errors = stim_errors + 1;
            $display("Could not open the stimulus file %s", STIM_FILE);
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%c %d %h %h %h", op, ce, a, d, e);
                    if (n == 5 && op != "#") begin
                        op_q.push_back(op);
                        ce_q.push_back(ce != 0);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        exp_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
        stim_lines = op_q.size();
        if (stim_lines == 0) begin
            stim_errors = stim_errors + 1;
            $display("No operations found in the stimulus file");
        end
    endtask

    // Checks the pending read first, then drives the next operation
    task automatic run_line(input int i);
        logic         exp_en;
        ppu_reg_sel_t exp_sel;
        @(negedge clock);
        if (read_pending) begin
            check_data(r_data, read_expect, $sformatf("r_data after read of %h", read_addr));
        end
        read_pending = 1'b0;
        clock_en = ce_q[i];
        addr     = addr_q[i];
        r_en     = 1'b1;
        case (op_q[i])
            "W": begin
                r_en   = 1'b0;
                w_data = data_q[i];
            end
            "R": begin
                read_pending = 1'b1;
                read_addr    = addr_q[i];
                read_expect  = exp_q[i];
            end
            "B": buttons = data_q[i];
            "P": reg_data_rd = data_q[i];
            default: begin
                stim_errors = stim_errors + 1;
                $display("Unknown operation '%c' on stim entry %0d", op_q[i], i);
            end
        endcase
        #(CLK_PERIOD / 4);
        ppu_sel_for_addr(addr, exp_en, exp_sel);
        check_flag(reg_en, exp_en, $sformatf("reg_en at %h", addr));
        if (exp_en) begin
            check_ppu_sel(reg_sel, exp_sel, $sformatf("reg_sel at %h", addr));
        end
        check_flag(reg_rw, !r_en, $sformatf("reg_rw at %h", addr));
        check_data(reg_data_wr, w_data, $sformatf("reg_data_wr at %h", addr));
    endtask

    initial begin
        clock_en    = 1'b0;
        addr        = '0;
        r_en        = 1'b1;
        w_data      = '0;
        buttons     = '0;
        reg_data_rd = '0;
        reset_n     = 1'b0;
        load_stim();
        stim_ready = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        foreach (op_q[i]) begin
            run_line(i);
        end
        @(negedge clock);
        if (read_pending) begin
            check_data(r_data, read_expect, $sformatf("r_data after read of %h", read_addr));
        end
        assert_fails = dut_i.decoder_i.props_i.failures;
        $display("Errors: data %0d, ppu select %0d, flag %0d, stim %0d, assertion %0d",
                 data_errors, sel_errors, flag_errors, stim_errors, assert_fails);
        if (data_errors + sel_errors + flag_errors + stim_errors + assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Four cycles per operation plus slack for reset
    initial begin
        wait (stim_ready);
        repeat (stim_lines * 4 + 20) @(posedge clock);
        $display("Timeout, the run did not finish within %0d cycles", stim_lines * 4 + 20);
        $display("Checks failed");
        $finish;
    end

endmodule : tb_cpu_bus

// File: verif/cpu_bus_stim.txt
# op ce addr data expect, all hex except the clock_en flag
# W write, R read (expect is r_data next cycle), B set buttons, P set PPU read byte
# RAM and its mirrors
W 1 0123 5A 00
R 1 0123 00 5A
R 1 0923 00 5A
R 1 1923 00 5A
W 1 07FF 81 00
R 1 1FFF 00 81
# Program ROM, write dropped
R 1 8000 00 78
R 1 FFFC 00 10
W 1 8000 FF 00
R 1 8000 00 78
# PPU registers, mirror and OAMDMA
W 1 2000 11 00
W 1 2001 12 00
W 1 2002 13 00
W 1 2003 14 00
W 1 2004 15 00
W 1 2005 16 00
W 1 2006 17 00
W 1 2007 18 00
W 1 3FFE 66 00
W 1 4014 02 00
P 0 0000 C5 00
R 1 2002 00 C5
P 0 0000 3A 00
R 1 3FFE 00 3A
# Controller latched with A5, eight bits then 1
B 0 0000 A5 00
W 1 4016 01 00
W 1 4016 00 00
R 1 4016 00 01
R 1 4016 00 00
R 1 4016 00 01
R 1 4016 00 00
R 1 4016 00 00
R 1 4016 00 01
R 1 4016 00 00
R 1 4016 00 01
R 1 4016 00 01
# Strobe held high returns A every read
B 0 0000 5A 00
W 1 4016 01 00
W 1 4016 01 00
R 1 4016 00 00
R 1 4016 00 00
# Unmapped space and a read with clock_en low
R 1 0123 00 5A
R 1 5000 00 00
R 1 0123 00 5A
R 0 8000 00 5A

// File: verif/prg_image.hex
// Program ROM image, one byte per entry
// @ gives the offset from $8000
@0000
78 D8 A9 10 8D 00 20 A2
FF 9A AD 02 20 10 FB 4C
// NMI, reset and IRQ vectors at $FFFA
@7FFA
50 80 10 80 90 80

// File: tb.f
logic/cpu_bus_pkg.sv
logic/work_ram.sv
logic/prg_rom.sv
logic/controller_port.sv
logic/cpu_bus_decoder.sv
logic/cpu_bus.sv
verif/cpu_bus_properties.sv
verif/tb_cpu_bus.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
SIMFLAGS  = +verilator+error+limit+1000
TOP       = tb_cpu_bus
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
